//--- bench/issue_trace.txt
# in: fl v ty o1 o2 op we sg wd rs1 rs2 rd pc imm rd0 rd1 ipr lsr fwd ipwb ipwd ipwr lswb lswd lswr busy wba wbd
# exp: rdy ipv ipd ipo ip1 ip2 lsv lsd lsb lss lso lsw lssg (hex, ready before edge, rest after)
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 0 0 0 0 0 0 0 0 0 0  1 0 0 0 0 0 0 0 0 0 0 0 0
0 1 0 0 0 0 1 0 0 1 2 3 100 0 a b 1 1 0 0 0 0 0 0 0 0 0 0  1 1 3 0 a b 0 0 0 0 0 0 0
0 1 0 1 1 8 1 0 0 0 0 4 104 7 0 0 1 1 0 0 0 0 0 0 0 0 0 0  1 1 4 8 104 7 0 0 0 0 0 0 0
0 1 0 2 2 4 1 0 0 0 0 5 108 0 0 0 1 1 0 0 0 0 0 0 0 0 0 0  1 1 5 4 0 4 0 0 0 0 0 0 0
0 1 0 0 0 6 0 0 0 0 0 6 10c 0 ff ee 1 1 0 0 0 0 0 0 0 0 0 0  1 1 6 6 0 0 0 0 0 0 0 0 0
0 1 0 0 1 0 1 0 0 3 0 7 110 1 0 0 1 1 0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0 0 0 0
0 1 0 0 1 0 1 0 0 3 0 7 110 1 0 0 1 1 0 1 3 33 0 0 0 0 0 0  1 1 7 0 33 1 0 0 0 0 0 0 0
0 1 0 0 0 0 1 0 0 7 5 8 114 0 0 0 1 1 77 1 5 55 0 0 0 0 0 0  1 1 8 0 77 55 0 0 0 0 0 0 0
0 1 0 0 1 0 1 0 0 4 0 9 118 2 0 0 1 1 0 1 4 44 1 4 4a 0 0 0  1 1 9 0 4a 2 0 0 0 0 0 0 0
0 1 1 0 1 0 1 1 2 1 0 a 200 123 1000 0 1 1 0 0 0 0 0 0 0 0 0 0  1 0 0 0 0 0 1 a 1000 123 123 2 1
0 1 2 0 0 0 0 0 3 2 1 0 204 8 2000 5555 1 1 0 0 0 0 0 0 0 0 0 0  1 0 0 0 0 0 1 0 2000 5555 8 3 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0  1 0 0 0 0 0 1 0 2000 5555 8 3 0
0 1 1 0 1 0 1 0 0 1 0 b 208 4 3000 0 1 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 1 0 2000 5555 8 3 0
0 1 1 0 1 0 1 0 0 1 0 b 208 4 3000 0 1 1 0 0 0 0 0 0 0 0 0 0  1 0 0 0 0 0 1 b 3000 4 4 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 0 0 0 0 0 0 0 0 0 0  1 0 0 0 0 0 0 0 0 0 0 0 0
0 1 0 2 2 0 1 0 0 0 0 a 20c 0 0 0 1 1 0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0 0 0 0
0 1 0 2 2 0 1 0 0 0 0 a 20c 0 0 0 1 1 0 0 0 0 0 0 0 0 1 a  1 1 a 0 0 4 0 0 0 0 0 0 0
0 1 3 2 2 0 0 0 0 0 0 0 210 0 0 0 1 1 0 0 0 0 0 0 0 1 0 0  0 0 0 0 0 0 0 0 0 0 0 0 0
0 1 3 2 2 0 0 0 0 0 0 0 210 0 0 0 1 1 0 0 0 0 1 b 0 0 0 0  0 0 0 0 0 0 0 0 0 0 0 0 0
0 1 3 2 2 0 0 0 0 0 0 0 210 0 0 0 1 1 0 0 0 0 0 0 0 0 0 0  1 0 0 0 0 0 0 0 0 0 0 0 0
0 1 1 0 1 0 1 0 3 1 0 d 214 0 4000 0 1 1 0 0 0 0 0 0 0 0 0 0  1 0 0 0 0 0 1 d 4000 0 0 3 0
0 1 0 2 2 0 1 0 0 0 0 c 218 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0  1 1 c 0 0 4 1 d 4000 0 0 3 0
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  1 0 0 0 0 0 0 0 0 0 0 0 0
0 1 0 0 1 0 1 0 0 c 0 e 21c 1 cc 0 1 1 0 0 0 0 0 0 0 0 0 0  1 1 e 0 cc 1 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 0 0 0 0 0 0 0 0 0 0  1 0 0 0 0 0 0 0 0 0 0 0 0

//--- issue_unit.f
common/issue_pkg.sv
issue/reg_scoreboard.sv
issue/operand_bypass.sv
issue/issue_select.sv
issue/issue_unit.sv
bench/tb_issue_unit.sv

//--- run_sim.sh
#!/bin/sh
# Builds the issue stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_issue_unit -f issue_unit.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_issue_unit > sim.log 2>&1
status=$?
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0

//--- bench/tb_issue_unit.sv
`timescale 1ns/1ns
`default_nettype none

module tb_issue_unit;

    logic clk;
    logic rst;
    logic pipe_flush;
    wire issue_pkg::reg_idx_t rf_rsrc0;
    wire issue_pkg::reg_idx_t rf_rsrc1;
    issue_pkg::xlen_t rf_rdata0;
    issue_pkg::xlen_t rf_rdata1;
    issue_pkg::xlen_t dec_ix_pc;
    issue_pkg::xlen_t dec_ix_imm;
    issue_pkg::alu_op_e dec_ix_op;
    logic dec_ix_option;
    logic dec_ix_wb_en;
    logic dec_ix_mem_sign;
    issue_pkg::op_type_e dec_ix_op_type;
    issue_pkg::opr1_sel_e dec_ix_operand1;
    issue_pkg::opr2_sel_e dec_ix_operand2;
    issue_pkg::mem_width_e dec_ix_mem_width;
    issue_pkg::reg_idx_t dec_ix_rs1;
    issue_pkg::reg_idx_t dec_ix_rs2;
    issue_pkg::reg_idx_t dec_ix_rd;
    logic dec_ix_valid;
    wire dec_ix_ready;
    wire issue_pkg::xlen_t ix_ip_pc;
    wire issue_pkg::xlen_t ix_ip_operand1;
    wire issue_pkg::xlen_t ix_ip_operand2;
    wire issue_pkg::reg_idx_t ix_ip_dst;
    wire issue_pkg::alu_op_e ix_ip_op;
    wire ix_ip_option;
    wire ix_ip_wb_en;
    wire ix_ip_valid;
    logic ix_ip_ready;
    issue_pkg::xlen_t ip_ix_forwarding;
    issue_pkg::xlen_t ip_wb_result;
    issue_pkg::xlen_t lsp_wb_result;
    issue_pkg::reg_idx_t ip_wb_dst;
    issue_pkg::reg_idx_t lsp_wb_dst;
    logic ip_wb_wb_en;
    logic ip_wb_valid;
    logic lsp_wb_wb_en;
    logic lsp_wb_valid;
    logic lsp_ix_mem_busy;
    wire issue_pkg::xlen_t ix_lsp_pc;
    wire issue_pkg::xlen_t ix_lsp_base;
    wire issue_pkg::xlen_t ix_lsp_source;
    wire issue_pkg::reg_idx_t ix_lsp_dst;
    wire issue_pkg::ls_offset_t ix_lsp_offset;
    wire ix_lsp_mem_sign;
    wire ix_lsp_wb_en;
    wire ix_lsp_valid;
    wire issue_pkg::mem_width_e ix_lsp_mem_width;
    logic ix_lsp_ready;
    logic wb_ix_active;
    issue_pkg::reg_idx_t wb_ix_dst;

    // Trace cells, 28 input columns then 13 expected columns per row
    logic [63:0] cells[$];
    int ncols = 41;
    int nrows = 0;
    logic trace_loaded = 1'b0;

    // Payload of the last instruction handed to each pipe
    issue_pkg::xlen_t exp_ip_pc;
    logic exp_ip_wb_en;
    logic exp_ip_option;
    issue_pkg::xlen_t exp_lsp_pc;
    logic exp_lsp_wb_en;

    issue_unit i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_failed();
        $display("RESULT: FAIL");
        $fatal(1, "Stopping at first error");
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] t=%0t %s expected=%b actual=%b", $time, name, exp, act);
            stop_failed();
        end
    endtask

    task automatic check_word(input string name, input issue_pkg::xlen_t exp,
                              input issue_pkg::xlen_t act);
        if (act !== exp) begin
            $display("[FAIL] t=%0t %s expected=%h actual=%h", $time, name, exp, act);
            stop_failed();
        end
    endtask

    task automatic check_reg(input string name, input issue_pkg::reg_idx_t exp,
                             input issue_pkg::reg_idx_t act);
        if (act !== exp) begin
            $display("[FAIL] t=%0t %s expected=%0d actual=%0d", $time, name, exp, act);
            stop_failed();
        end
    endtask

    task automatic check_op(input string name, input issue_pkg::alu_op_e exp,
                            input issue_pkg::alu_op_e act);
        if (act !== exp) begin
            $display("[FAIL] t=%0t %s expected=%h actual=%h", $time, name, exp, act);
            stop_failed();
        end
    endtask

    task automatic check_width(input string name, input issue_pkg::mem_width_e exp,
                               input issue_pkg::mem_width_e act);
        if (act !== exp) begin
            $display("[FAIL] t=%0t %s expected=%h actual=%h", $time, name, exp, act);
            stop_failed();
        end
    endtask

    // Lines starting with # are column notes
    task automatic load_trace();
        int fd;
        int c;
        int n;
        string tok;
        string rest;
        logic [63:0] v;
        fd = $fopen("bench/issue_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file bench/issue_trace.txt");
            stop_failed();
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok.getc(0) == 8'h23) begin
                n = $fgets(rest, fd);
                continue;
            end
            n = $sscanf(tok, "%h", v);
            cells.push_back(v);
            for (c = 1; c < ncols; c++) begin
                if ($fscanf(fd, "%h", v) != 1) begin
                    $display("Trace row %0d is missing columns", nrows);
                    stop_failed();
                end
                cells.push_back(v);
            end
            nrows++;
        end
        $fclose(fd);
        trace_loaded = 1'b1;
    endtask

    task automatic drive_row(input int r);
        int b;
        b = r * ncols;
        pipe_flush       = cells[b][0];
        dec_ix_valid     = cells[b+1][0];
        dec_ix_op_type   = issue_pkg::op_type_e'(cells[b+2][1:0]);
        dec_ix_operand1  = issue_pkg::opr1_sel_e'(cells[b+3][1:0]);
        dec_ix_operand2  = issue_pkg::opr2_sel_e'(cells[b+4][1:0]);
        dec_ix_op        = issue_pkg::alu_op_e'(cells[b+5][3:0]);
        dec_ix_wb_en     = cells[b+6][0];
        dec_ix_mem_sign  = cells[b+7][0];
        dec_ix_mem_width = issue_pkg::mem_width_e'(cells[b+8][1:0]);
        dec_ix_rs1       = cells[b+9][4:0];
        dec_ix_rs2       = cells[b+10][4:0];
        dec_ix_rd        = cells[b+11][4:0];
        dec_ix_pc        = cells[b+12];
        // Option bit follows pc bit 2, so both values reach the integer pipe
        dec_ix_option    = cells[b+12][2];
        dec_ix_imm       = cells[b+13];
        rf_rdata0        = cells[b+14];
        rf_rdata1        = cells[b+15];
        ix_ip_ready      = cells[b+16][0];
        ix_lsp_ready     = cells[b+17][0];
        ip_ix_forwarding = cells[b+18];
        ip_wb_valid      = cells[b+19][0];
        ip_wb_wb_en      = cells[b+19][0];
        ip_wb_dst        = cells[b+20][4:0];
        ip_wb_result     = cells[b+21];
        lsp_wb_valid     = cells[b+22][0];
        lsp_wb_wb_en     = cells[b+22][0];
        lsp_wb_dst       = cells[b+23][4:0];
        lsp_wb_result    = cells[b+24];
        lsp_ix_mem_busy  = cells[b+25][0];
        wb_ix_active     = cells[b+26][0];
        wb_ix_dst        = cells[b+27][4:0];
    endtask

    // Valid and expected ready with no flush hands the instruction to its pipe
    task automatic note_accepted(input int r);
        int b;
        issue_pkg::op_type_e ty;
        b = r * ncols;
        ty = issue_pkg::op_type_e'(cells[b+2][1:0]);
        if (cells[b+28][0] && cells[b+1][0] && !cells[b][0]) begin
            if (ty == issue_pkg::op_int) begin
                exp_ip_pc     = dec_ix_pc;
                exp_ip_wb_en  = dec_ix_wb_en;
                exp_ip_option = dec_ix_option;
            end else if (ty == issue_pkg::op_load || ty == issue_pkg::op_store) begin
                exp_lsp_pc    = dec_ix_pc;
                exp_lsp_wb_en = dec_ix_wb_en;
            end
        end
    endtask

    // Output stages after the edge; payload only matters while valid
    task automatic check_outputs(input int r);
        int b;
        b = r * ncols;
        check_bit("ix_ip_valid", cells[b+29][0], ix_ip_valid);
        if (cells[b+29][0]) begin
            check_reg("ix_ip_dst", cells[b+30][4:0], ix_ip_dst);
            check_op("ix_ip_op", issue_pkg::alu_op_e'(cells[b+31][3:0]), ix_ip_op);
            check_word("ix_ip_operand1", cells[b+32], ix_ip_operand1);
            check_word("ix_ip_operand2", cells[b+33], ix_ip_operand2);
            check_word("ix_ip_pc", exp_ip_pc, ix_ip_pc);
            check_bit("ix_ip_wb_en", exp_ip_wb_en, ix_ip_wb_en);
            check_bit("ix_ip_option", exp_ip_option, ix_ip_option);
        end
        check_bit("ix_lsp_valid", cells[b+34][0], ix_lsp_valid);
        if (cells[b+34][0]) begin
            check_reg("ix_lsp_dst", cells[b+35][4:0], ix_lsp_dst);
            check_word("ix_lsp_base", cells[b+36], ix_lsp_base);
            check_word("ix_lsp_source", cells[b+37], ix_lsp_source);
            check_word("ix_lsp_offset", cells[b+38], issue_pkg::xlen_t'(ix_lsp_offset));
            check_width("ix_lsp_mem_width", issue_pkg::mem_width_e'(cells[b+39][1:0]),
                        ix_lsp_mem_width);
            check_bit("ix_lsp_mem_sign", cells[b+40][0], ix_lsp_mem_sign);
            check_word("ix_lsp_pc", exp_lsp_pc, ix_lsp_pc);
            check_bit("ix_lsp_wb_en", exp_lsp_wb_en, ix_lsp_wb_en);
        end
    endtask

    initial begin
        int r;
        rst = 1'b1;
        pipe_flush = 1'b0;
        rf_rdata0 = '0;
        rf_rdata1 = '0;
        dec_ix_pc = '0;
        dec_ix_imm = '0;
        dec_ix_op = issue_pkg::alu_add;
        dec_ix_option = 1'b0;
        dec_ix_wb_en = 1'b0;
        dec_ix_mem_sign = 1'b0;
        dec_ix_op_type = issue_pkg::op_int;
        dec_ix_operand1 = issue_pkg::opr1_rs1;
        dec_ix_operand2 = issue_pkg::opr2_rs2;
        dec_ix_mem_width = issue_pkg::mem_byte;
        dec_ix_rs1 = '0;
        dec_ix_rs2 = '0;
        dec_ix_rd = '0;
        dec_ix_valid = 1'b0;
        ix_ip_ready = 1'b1;
        ix_lsp_ready = 1'b1;
        ip_ix_forwarding = '0;
        ip_wb_result = '0;
        lsp_wb_result = '0;
        ip_wb_dst = '0;
        lsp_wb_dst = '0;
        ip_wb_wb_en = 1'b0;
        ip_wb_valid = 1'b0;
        lsp_wb_wb_en = 1'b0;
        lsp_wb_valid = 1'b0;
        lsp_ix_mem_busy = 1'b0;
        wb_ix_active = 1'b0;
        wb_ix_dst = '0;
        load_trace();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (r = 0; r < nrows; r++) begin
            drive_row(r);
            // Ready is seen just before the rising edge
            #19;
            check_bit("dec_ix_ready", cells[r*ncols+28][0], dec_ix_ready);
            // Register file addresses come straight from the decoded sources
            check_reg("rf_rsrc0", cells[r*ncols+9][4:0], rf_rsrc0);
            check_reg("rf_rsrc1", cells[r*ncols+10][4:0], rf_rsrc1);
            note_accepted(r);
            #20;
            check_outputs(r);
            @(negedge clk);
        end
        $display("RESULT: PASS");
        $finish;
    end

    initial begin
        wait (trace_loaded);
        #(2 * nrows * 40 + 400);
        $display("Timeout: the trace did not finish in the expected time");
        stop_failed();
    end

endmodule

`default_nettype wire

//--- issue/issue_unit.sv
`timescale 1ns/1ns
`default_nettype none

module issue_unit (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         pipe_flush,
    // Register file read ports
    output wire issue_pkg::reg_idx_t    rf_rsrc0,
    output wire issue_pkg::reg_idx_t    rf_rsrc1,
    input  wire issue_pkg::xlen_t       rf_rdata0,
    input  wire issue_pkg::xlen_t       rf_rdata1,
    // From decode
    input  wire issue_pkg::xlen_t       dec_ix_pc,
    input  wire issue_pkg::xlen_t       dec_ix_imm,
    input  wire issue_pkg::alu_op_e     dec_ix_op,
    input  wire                         dec_ix_option,
    input  wire                         dec_ix_wb_en,
    input  wire                         dec_ix_mem_sign,
    input  wire issue_pkg::op_type_e    dec_ix_op_type,
    input  wire issue_pkg::opr1_sel_e   dec_ix_operand1,
    input  wire issue_pkg::opr2_sel_e   dec_ix_operand2,
    input  wire issue_pkg::mem_width_e  dec_ix_mem_width,
    input  wire issue_pkg::reg_idx_t    dec_ix_rs1,
    input  wire issue_pkg::reg_idx_t    dec_ix_rs2,
    input  wire issue_pkg::reg_idx_t    dec_ix_rd,
    input  wire                         dec_ix_valid,
    output wire                         dec_ix_ready,
    // To integer pipe
    output wire issue_pkg::xlen_t       ix_ip_pc,
    output wire issue_pkg::xlen_t       ix_ip_operand1,
    output wire issue_pkg::xlen_t       ix_ip_operand2,
    output wire issue_pkg::reg_idx_t    ix_ip_dst,
    output wire issue_pkg::alu_op_e     ix_ip_op,
    output wire                         ix_ip_option,
    output wire                         ix_ip_wb_en,
    output wire                         ix_ip_valid,
    input  wire                         ix_ip_ready,
    // Forwarding sources
    input  wire issue_pkg::xlen_t       ip_ix_forwarding,
    input  wire issue_pkg::xlen_t       ip_wb_result,
    input  wire issue_pkg::xlen_t       lsp_wb_result,
    input  wire issue_pkg::reg_idx_t    ip_wb_dst,
    input  wire issue_pkg::reg_idx_t    lsp_wb_dst,
    input  wire                         ip_wb_wb_en,
    input  wire                         ip_wb_valid,
    input  wire                         lsp_wb_wb_en,
    input  wire                         lsp_wb_valid,
    input  wire                         lsp_ix_mem_busy,
    // To load/store pipe
    output wire issue_pkg::xlen_t       ix_lsp_pc,
    output wire issue_pkg::xlen_t       ix_lsp_base,
    output wire issue_pkg::xlen_t       ix_lsp_source,
    output wire issue_pkg::reg_idx_t    ix_lsp_dst,
    output wire issue_pkg::ls_offset_t  ix_lsp_offset,
    output wire                         ix_lsp_mem_sign,
    output wire                         ix_lsp_wb_en,
    output wire                         ix_lsp_valid,
    output wire issue_pkg::mem_width_e  ix_lsp_mem_width,
    input  wire                         ix_lsp_ready,
    // Final writeback
    input  wire                         wb_ix_active,
    input  wire issue_pkg::reg_idx_t    wb_ix_dst
);

    wire issue_pkg::reg_owner_e rs1_owner;
    wire issue_pkg::reg_owner_e rs2_owner;
    wire issue_pkg::reg_owner_e rd_owner;
    wire issue_pkg::xlen_t operand1_value;
    wire issue_pkg::xlen_t operand2_value;
    wire operands_ready;
    wire issue_int;
    wire issue_ls;

    assign rf_rsrc0 = dec_ix_rs1;
    assign rf_rsrc1 = dec_ix_rs2;

    reg_scoreboard i_scoreboard (
        .rs1   (dec_ix_rs1),
        .rs2   (dec_ix_rs2),
        .rd    (dec_ix_rd),
        .wb_en (dec_ix_wb_en),
        .*
    );

    operand_bypass i_bypass (
        .rs1 (dec_ix_rs1),
        .rs2 (dec_ix_rs2),
        .*
    );

    issue_select i_select (
        .*
    );

endmodule

`default_nettype wire

//--- issue/issue_select.sv
`timescale 1ns/1ns
`default_nettype none

module issue_select (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         pipe_flush,
    input  wire issue_pkg::xlen_t       dec_ix_pc,
    input  wire issue_pkg::xlen_t       dec_ix_imm,
    input  wire issue_pkg::alu_op_e     dec_ix_op,
    input  wire                         dec_ix_option,
    input  wire                         dec_ix_wb_en,
    input  wire                         dec_ix_mem_sign,
    input  wire issue_pkg::op_type_e    dec_ix_op_type,
    input  wire issue_pkg::mem_width_e  dec_ix_mem_width,
    input  wire issue_pkg::reg_idx_t    dec_ix_rd,
    input  wire                         dec_ix_valid,
    output wire                         dec_ix_ready,
    input  wire issue_pkg::xlen_t       operand1_value,
    input  wire issue_pkg::xlen_t       operand2_value,
    input  wire                         operands_ready,
    input  wire issue_pkg::reg_owner_e  rd_owner,
    input  wire                         wb_ix_active,
    input  wire issue_pkg::reg_idx_t    wb_ix_dst,
    input  wire                         ix_ip_ready,
    input  wire                         ix_lsp_ready,
    input  wire                         lsp_ix_mem_busy,
    input  wire                         lsp_wb_valid,
    input  wire                         lsp_wb_wb_en,
    output wire                         issue_int,
    output wire                         issue_ls,
    // Integer pipe output stage
    output issue_pkg::xlen_t            ix_ip_pc,
    output issue_pkg::xlen_t            ix_ip_operand1,
    output issue_pkg::xlen_t            ix_ip_operand2,
    output issue_pkg::reg_idx_t         ix_ip_dst,
    output issue_pkg::alu_op_e          ix_ip_op,
    output logic                        ix_ip_option,
    output logic                        ix_ip_wb_en,
    output logic                        ix_ip_valid,
    // Load/store pipe output stage
    output issue_pkg::xlen_t            ix_lsp_pc,
    output issue_pkg::xlen_t            ix_lsp_base,
    output issue_pkg::xlen_t            ix_lsp_source,
    output issue_pkg::reg_idx_t         ix_lsp_dst,
    output issue_pkg::ls_offset_t       ix_lsp_offset,
    output logic                        ix_lsp_mem_sign,
    output logic                        ix_lsp_wb_en,
    output logic                        ix_lsp_valid,
    output issue_pkg::mem_width_e       ix_lsp_mem_width
);

    wire issue_common = dec_ix_valid && operands_ready && !pipe_flush;

    // A pending load result on rd would land after the integer write
    wire rd_freed_now = wb_ix_active && (wb_ix_dst == dec_ix_rd);
    wire waw_int = (rd_owner == issue_pkg::owner_ls) && !rd_freed_now;

    wire is_int = (dec_ix_op_type == issue_pkg::op_int);
    wire is_mem = (dec_ix_op_type == issue_pkg::op_load) ||
                  (dec_ix_op_type == issue_pkg::op_store);
    wire is_fence = (dec_ix_op_type == issue_pkg::op_fence);

    assign issue_int = issue_common && ix_ip_ready && !waw_int && is_int;
    assign issue_ls  = issue_common && ix_lsp_ready && is_mem;

    // Fence retires in place once no memory access is left in flight
    wire ls_drained = !ix_lsp_valid && !lsp_ix_mem_busy && !(lsp_wb_valid && lsp_wb_wb_en);
    wire fence_done = dec_ix_valid && is_fence && ls_drained;

    wire stall = dec_ix_valid && !(issue_int || issue_ls || fence_done) && !pipe_flush;
    assign dec_ix_ready = !rst && !stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            ix_ip_valid <= 1'b0;
        end else if (issue_int) begin
            ix_ip_valid <= 1'b1;
        end else if (ix_ip_ready || pipe_flush) begin
            ix_ip_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ix_lsp_valid <= 1'b0;
        end else if (issue_ls) begin
            ix_lsp_valid <= 1'b1;
        end else if (ix_lsp_ready || pipe_flush) begin
            ix_lsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_int) begin
            ix_ip_pc       <= dec_ix_pc;
            ix_ip_operand1 <= operand1_value;
            ix_ip_operand2 <= operand2_value;
            ix_ip_dst      <= dec_ix_rd;
            ix_ip_op       <= dec_ix_op;
            ix_ip_option   <= dec_ix_option;
            ix_ip_wb_en    <= dec_ix_wb_en;
        end
    end

    // Operand 1 is the address base, operand 2 the store data
    always_ff @(posedge clk) begin
        if (issue_ls) begin
            ix_lsp_pc        <= dec_ix_pc;
            ix_lsp_base      <= operand1_value;
            ix_lsp_source    <= operand2_value;
            ix_lsp_dst       <= dec_ix_rd;
            ix_lsp_offset    <= dec_ix_imm[issue_pkg::ls_offset_w-1:0];
            ix_lsp_mem_sign  <= dec_ix_mem_sign;
            ix_lsp_wb_en     <= dec_ix_wb_en;
            ix_lsp_mem_width <= dec_ix_mem_width;
        end
    end

endmodule

`default_nettype wire

//--- issue/operand_bypass.sv
`timescale 1ns/1ns
`default_nettype none

module operand_bypass (
    input  wire issue_pkg::xlen_t       rf_rdata0,
    input  wire issue_pkg::xlen_t       rf_rdata1,
    input  wire issue_pkg::reg_idx_t    rs1,
    input  wire issue_pkg::reg_idx_t    rs2,
    input  wire issue_pkg::reg_owner_e  rs1_owner,
    input  wire issue_pkg::reg_owner_e  rs2_owner,
    input  wire issue_pkg::xlen_t       dec_ix_pc,
    input  wire issue_pkg::xlen_t       dec_ix_imm,
    input  wire issue_pkg::opr1_sel_e   dec_ix_operand1,
    input  wire issue_pkg::opr2_sel_e   dec_ix_operand2,
    input  wire                         ix_ip_valid,
    input  wire                         ix_ip_ready,
    input  wire                         ix_ip_wb_en,
    input  wire issue_pkg::reg_idx_t    ix_ip_dst,
    input  wire issue_pkg::xlen_t       ip_ix_forwarding,
    input  wire issue_pkg::reg_idx_t    ip_wb_dst,
    input  wire issue_pkg::xlen_t       ip_wb_result,
    input  wire                         ip_wb_wb_en,
    input  wire                         ip_wb_valid,
    input  wire issue_pkg::reg_idx_t    lsp_wb_dst,
    input  wire issue_pkg::xlen_t       lsp_wb_result,
    input  wire                         lsp_wb_wb_en,
    input  wire                         lsp_wb_valid,
    output issue_pkg::xlen_t            operand1_value,
    output issue_pkg::xlen_t            operand2_value,
    output logic                        operands_ready
);

    // Integer result leaving the output stage this cycle
    wire ip_ex_active  = ix_ip_valid && ix_ip_ready && ix_ip_wb_en;
    wire ip_wb_active  = ip_wb_valid && ip_wb_wb_en;
    wire lsp_wb_active = lsp_wb_valid && lsp_wb_wb_en;

    for (genvar g = 0; g < 2; g++) begin : src
        wire issue_pkg::reg_idx_t idx = (g == 0) ? rs1 : rs2;
        wire issue_pkg::xlen_t rdata = (g == 0) ? rf_rdata0 : rf_rdata1;
        wire issue_pkg::reg_owner_e owner = (g == 0) ? rs1_owner : rs2_owner;
        issue_pkg::xlen_t value;
        logic ready;

        always_comb begin
            ready = (owner == issue_pkg::owner_free);
            value = rdata;
            // Youngest producer is checked last
            if (ip_wb_active && (ip_wb_dst == idx)) begin
                ready = 1'b1;
                value = ip_wb_result;
            end
            if (ip_ex_active && (ix_ip_dst == idx)) begin
                ready = 1'b1;
                value = ip_ix_forwarding;
            end
            if (lsp_wb_active && (lsp_wb_dst == idx)) begin
                ready = 1'b1;
                value = lsp_wb_result;
            end
            // x0 wins over any forwarded write to it
            if (idx == '0) begin
                ready = 1'b1;
                value = '0;
            end
        end
    end

    always_comb begin
        case (dec_ix_operand1)
            issue_pkg::opr1_rs1:  operand1_value = src[0].value;
            issue_pkg::opr1_pc:   operand1_value = dec_ix_pc;
            issue_pkg::opr1_zero: operand1_value = '0;
            default:              operand1_value = '0;
        endcase

        case (dec_ix_operand2)
            issue_pkg::opr2_rs2:  operand2_value = src[1].value;
            issue_pkg::opr2_imm:  operand2_value = dec_ix_imm;
            issue_pkg::opr2_four: operand2_value = issue_pkg::xlen_t'(4);
            default:              operand2_value = '0;
        endcase
    end

    // Unselected register sources never hold up issue
    always_comb begin
        operands_ready = ((dec_ix_operand1 != issue_pkg::opr1_rs1) || src[0].ready) &&
                         ((dec_ix_operand2 != issue_pkg::opr2_rs2) || src[1].ready);
    end

endmodule

`default_nettype wire

//--- issue/reg_scoreboard.sv
`timescale 1ns/1ns
`default_nettype none

module reg_scoreboard (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         pipe_flush,
    input  wire issue_pkg::reg_idx_t    rs1,
    input  wire issue_pkg::reg_idx_t    rs2,
    input  wire issue_pkg::reg_idx_t    rd,
    input  wire                         issue_int,
    input  wire                         issue_ls,
    input  wire                         wb_en,
    input  wire                         wb_ix_active,
    input  wire issue_pkg::reg_idx_t    wb_ix_dst,
    output issue_pkg::reg_owner_e       rs1_owner,
    output issue_pkg::reg_owner_e       rs2_owner,
    output issue_pkg::reg_owner_e       rd_owner
);

    // x0 is never written, so it has no entry
    issue_pkg::reg_owner_e owner_table [1:issue_pkg::num_regs-1];

    // Destination claimed in the previous cycle, undone on a flush
    issue_pkg::reg_idx_t cancel_idx;

    assign rs1_owner = (rs1 == '0) ? issue_pkg::owner_free : owner_table[rs1];
    assign rs2_owner = (rs2 == '0) ? issue_pkg::owner_free : owner_table[rs2];
    assign rd_owner  = (rd == '0) ? issue_pkg::owner_free : owner_table[rd];

    // Later assignments win: writeback free, then issue claim, then flush cancel
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < issue_pkg::num_regs; i++) begin
                owner_table[i] <= issue_pkg::owner_free;
            end
            cancel_idx <= '0;
        end else begin
            if (wb_ix_active && (wb_ix_dst != '0)) begin
                owner_table[wb_ix_dst] <= issue_pkg::owner_free;
            end

            if (issue_int || issue_ls) begin
                if (wb_en) begin
                    if (rd != '0) begin
                        owner_table[rd] <= issue_int ? issue_pkg::owner_int
                                                     : issue_pkg::owner_ls;
                    end
                    cancel_idx <= rd;
                end else begin
                    // Nothing to undo for an instruction without a destination
                    cancel_idx <= '0;
                end
            end

            // Only the instruction issued one cycle before the flush is in reach
            if (pipe_flush && (cancel_idx != '0)) begin
                owner_table[cancel_idx] <= issue_pkg::owner_free;
            end
        end
    end

endmodule

`default_nettype wire

//--- common/issue_pkg.sv
`default_nettype none

package issue_pkg;

    // Datapath and register file sizes
    localparam int xlen = 64;
    localparam int num_regs = 32;
    localparam int ls_offset_w = 12;

    typedef logic [xlen-1:0] xlen_t;
    typedef logic [$clog2(num_regs)-1:0] reg_idx_t;
    typedef logic [ls_offset_w-1:0] ls_offset_t;

    // Issue class of a decoded instruction
    typedef enum logic [1:0] {
        op_int   = 2'd0,
        op_load  = 2'd1,
        op_store = 2'd2,
        op_fence = 2'd3
    } op_type_e;

    typedef enum logic [1:0] {
        opr1_rs1  = 2'd0,
        opr1_pc   = 2'd1,
        opr1_zero = 2'd2
    } opr1_sel_e;

    typedef enum logic [1:0] {
        opr2_rs2  = 2'd0,
        opr2_imm  = 2'd1,
        opr2_four = 2'd2
    } opr2_sel_e;

    // Integer opcode, carried unchanged to the integer pipe
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sll  = 4'd1,
        alu_slt  = 4'd2,
        alu_sltu = 4'd3,
        alu_xor  = 4'd4,
        alu_srl  = 4'd5,
        alu_or   = 4'd6,
        alu_and  = 4'd7,
        alu_sub  = 4'd8,
        alu_sra  = 4'd9
    } alu_op_e;

    typedef enum logic [1:0] {
        mem_byte  = 2'd0,
        mem_half  = 2'd1,
        mem_word  = 2'd2,
        mem_dword = 2'd3
    } mem_width_e;

    // Which pipe will write a pending destination
    typedef enum logic [1:0] {
        owner_free = 2'd0,
        owner_int  = 2'd1,
        owner_ls   = 2'd2
    } reg_owner_e;

endpackage

`default_nettype wire
